// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_i2c_reg_master
FILELIST  ?= i2c_reg_master.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: i2c_bit_engine.sv
`timescale 1ns/1ps

module i2c_bit_engine #(
    parameter int CLK_DIV = 125  // COUNT cycles per quarter SCL period
) (
    input  logic                  COUNT,
    input  logic                  reset_n,
    input  logic                  cmd_valid,
    input  i2c_reg_pkg::bit_cmd_e cmd,
    input  logic                  tx_bit,
    input  logic                  sda_in,
    output logic                  bit_done,
    output logic                  rx_bit,
    output logic                  scl_low,
    output logic                  sda_low
);
    import i2c_reg_pkg::*;

    localparam int DIV_W = $clog2(CLK_DIV);
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(CLK_DIV - 1);

    logic [DIV_W-1:0] div_cnt;
    logic [1:0]       quarter;
    logic             running;
    bit_cmd_e         cmd_q;

    bit_cmd_e         sel_cmd;
    logic [1:0]       sel_q;
    logic             quarter_end;
    logic             load_lvl;
    logic             sample;
    logic             scl_nxt;
    logic             sda_nxt;

    assign quarter_end = running && (div_cnt == DIV_LAST);

    // New levels at command accept and at every quarter boundary except the last
    assign load_lvl = (!running && cmd_valid) || (quarter_end && quarter != 2'd3);

    // Mid SCL high is the boundary between quarter 1 and 2
    assign sample = quarter_end && (quarter == 2'd1) && (cmd_q == BIT_READ);

    // Pick the command and the quarter whose levels are loaded next
    always_comb begin
        if (running) begin
            sel_cmd = cmd_q;
            sel_q   = quarter + 2'd1;
        end else begin
            sel_cmd = cmd;
            sel_q   = 2'd0;
        end
    end

    // Pull-down levels per quarter, anything not named holds its level
    always_comb begin
        scl_nxt = scl_low;
        sda_nxt = sda_low;
        case (sel_cmd)
            BIT_START: begin
                case (sel_q)
                    2'd0:    sda_nxt = 1'b0;  // Release SDA, SCL as it was
                    2'd1:    scl_nxt = 1'b0;  // SCL up with SDA high
                    2'd2:    sda_nxt = 1'b1;  // SDA falls while SCL high
                    default: scl_nxt = 1'b1;
                endcase
            end
            BIT_STOP: begin
                case (sel_q)
                    2'd0:    sda_nxt = 1'b1;  // SDA low while SCL still low
                    2'd1:    scl_nxt = 1'b0;
                    2'd2:    sda_nxt = 1'b0;  // SDA rises while SCL high
                    default: scl_nxt = 1'b0;
                endcase
            end
            BIT_WRITE: begin
                case (sel_q)
                    2'd0: begin
                        scl_nxt = 1'b1;
                        sda_nxt = ~tx_bit;    // Data set up during SCL low
                    end
                    2'd1:    scl_nxt = 1'b0;
                    2'd2:    scl_nxt = 1'b0;
                    default: scl_nxt = 1'b1;  // SDA held past the falling edge
                endcase
            end
            default: begin
                // Read, SDA left to the slave
                case (sel_q)
                    2'd0: begin
                        scl_nxt = 1'b1;
                        sda_nxt = 1'b0;
                    end
                    2'd1:    scl_nxt = 1'b0;
                    2'd2:    scl_nxt = 1'b0;
                    default: scl_nxt = 1'b1;
                endcase
            end
        endcase
    end

    always_ff @(posedge COUNT) begin
        if (!reset_n) begin
            running  <= 1'b0;
            div_cnt  <= '0;
            quarter  <= 2'd0;
            bit_done <= 1'b0;
            scl_low  <= 1'b0;
            sda_low  <= 1'b0;
        end else begin
            bit_done <= 1'b0;
            if (!running) begin
                if (cmd_valid) begin
                    running <= 1'b1;
                    div_cnt <= '0;
                    quarter <= 2'd0;
                end
            end else if (quarter_end) begin
                div_cnt <= '0;
                if (quarter == 2'd3) begin
                    running  <= 1'b0;
                    bit_done <= 1'b1;
                end else begin
                    quarter <= quarter + 2'd1;
                end
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end

            if (load_lvl) begin
                scl_low <= scl_nxt;
                sda_low <= sda_nxt;
            end
        end
    end

    // Command and sampled bit
    always_ff @(posedge COUNT) begin
        if (!running && cmd_valid)
            cmd_q <= cmd;
        if (sample)
            rx_bit <= sda_in;
    end

endmodule

// File: i2c_byte_controller.sv
`timescale 1ns/1ps

module i2c_byte_controller (
    input  logic                   COUNT,
    input  logic                   reset_n,
    input  logic                   start,
    input  logic                   rw,
    input  i2c_reg_pkg::dev_addr_t dev_addr,
    input  i2c_reg_pkg::byte_t     reg_addr,
    input  i2c_reg_pkg::byte_t     wr_data,
    input  logic                   bit_done,
    input  logic                   rx_bit,
    output logic                   cmd_valid,
    output i2c_reg_pkg::bit_cmd_e  cmd,
    output logic                   tx_bit,
    output i2c_reg_pkg::byte_t     rd_data,
    output logic                   busy,
    output logic                   done,
    output logic                   ack_error
);
    import i2c_reg_pkg::*;

    seq_state_e state;
    seq_state_e state_nxt;
    logic [1:0] byte_idx;   // 0 dev W, 1 register, 2 data or dev R
    logic [1:0] idx_nxt;
    logic [2:0] bit_cnt;
    logic [2:0] cnt_nxt;

    // Operands captured at start
    logic       rw_q;
    dev_addr_t  dev_q;
    byte_t      reg_q;
    byte_t      data_q;

    byte_t      shift_q;
    byte_t      shift_nxt;
    logic [1:0] load_idx;
    byte_t      load_byte;

    logic       accept;
    logic       issue;
    bit_cmd_e   issue_cmd;
    logic       issue_tx;
    logic       nack_seen;
    logic       finish;

    assign accept = (state == IDLE) && start;  // Start while busy never reaches IDLE
    assign busy   = (state != IDLE);

    // Byte to send next, after START or after an acknowledged byte
    assign load_idx = (state == GET_ACK) ? byte_idx + 2'd1 : byte_idx;

    always_comb begin
        case (load_idx)
            2'd0:    load_byte = {dev_q, 1'b0};
            2'd1:    load_byte = reg_q;
            default: load_byte = rw_q ? {dev_q, 1'b1} : data_q;
        endcase
    end

    always_comb begin
        state_nxt = state;
        idx_nxt   = byte_idx;
        cnt_nxt   = bit_cnt;
        shift_nxt = shift_q;
        issue     = 1'b0;
        issue_cmd = BIT_WRITE;
        issue_tx  = 1'b1;
        nack_seen = 1'b0;
        finish    = 1'b0;
        case (state)
            IDLE: begin
                if (start) begin
                    state_nxt = SEND_START;
                    idx_nxt   = 2'd0;
                    issue     = 1'b1;
                    issue_cmd = BIT_START;
                end
            end
            SEND_START: begin
                if (bit_done) begin
                    state_nxt = SEND_BYTE;
                    shift_nxt = load_byte;
                    cnt_nxt   = 3'd0;
                    issue     = 1'b1;
                    issue_tx  = load_byte[7];
                end
            end
            SEND_BYTE: begin
                if (bit_done) begin
                    issue = 1'b1;
                    if (bit_cnt == 3'd7) begin
                        state_nxt = GET_ACK;
                        issue_cmd = BIT_READ;  // Slave ACK slot
                    end else begin
                        shift_nxt = {shift_q[6:0], 1'b0};
                        cnt_nxt   = bit_cnt + 3'd1;
                        issue_tx  = shift_q[6];
                    end
                end
            end
            GET_ACK: begin
                if (bit_done) begin
                    issue = 1'b1;
                    if (rx_bit) begin
                        // No ACK, abort with STOP
                        nack_seen = 1'b1;
                        state_nxt = SEND_STOP;
                        issue_cmd = BIT_STOP;
                    end else if (byte_idx == 2'd2 && rw_q) begin
                        state_nxt = RECV_BYTE;
                        cnt_nxt   = 3'd0;
                        issue_cmd = BIT_READ;
                    end else if (byte_idx == 2'd2) begin
                        state_nxt = SEND_STOP;
                        issue_cmd = BIT_STOP;
                    end else if (byte_idx == 2'd1 && rw_q) begin
                        state_nxt = SEND_START;  // Repeated START before dev R
                        idx_nxt   = 2'd2;
                        issue_cmd = BIT_START;
                    end else begin
                        state_nxt = SEND_BYTE;
                        idx_nxt   = byte_idx + 2'd1;
                        shift_nxt = load_byte;
                        cnt_nxt   = 3'd0;
                        issue_tx  = load_byte[7];
                    end
                end
            end
            RECV_BYTE: begin
                if (bit_done) begin
                    issue = 1'b1;
                    if (bit_cnt == 3'd7) begin
                        state_nxt = SEND_NACK;  // Write of a one is the NACK
                    end else begin
                        cnt_nxt   = bit_cnt + 3'd1;
                        issue_cmd = BIT_READ;
                    end
                end
            end
            SEND_NACK: begin
                if (bit_done) begin
                    state_nxt = SEND_STOP;
                    issue     = 1'b1;
                    issue_cmd = BIT_STOP;
                end
            end
            SEND_STOP: begin
                if (bit_done) begin
                    state_nxt = IDLE;
                    finish    = 1'b1;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge COUNT) begin
        if (!reset_n) begin
            state     <= IDLE;
            byte_idx  <= 2'd0;
            bit_cnt   <= 3'd0;
            cmd_valid <= 1'b0;
            done      <= 1'b0;
            ack_error <= 1'b0;
        end else begin
            state     <= state_nxt;
            byte_idx  <= idx_nxt;
            bit_cnt   <= cnt_nxt;
            cmd_valid <= issue;
            done      <= finish;
            if (accept)
                ack_error <= 1'b0;
            else if (nack_seen)
                ack_error <= 1'b1;
        end
    end

    // Operands, shift path and read data
    always_ff @(posedge COUNT) begin
        if (accept) begin
            rw_q   <= rw;
            dev_q  <= dev_addr;
            reg_q  <= reg_addr;
            data_q <= wr_data;
        end
        shift_q <= shift_nxt;
        if (issue) begin
            cmd    <= issue_cmd;
            tx_bit <= issue_tx;
        end
        if (state == RECV_BYTE && bit_done)
            rd_data <= {rd_data[6:0], rx_bit};  // MSB arrives first
    end

endmodule

// File: i2c_reg_master.f
i2c_reg_pkg.sv
i2c_bit_engine.sv
i2c_byte_controller.sv
i2c_reg_master.sv
i2c_slave_model.sv
tb_i2c_reg_master.sv

// File: i2c_reg_master.sv
`timescale 1ns/1ps

module i2c_reg_master #(
    parameter int CLK_DIV = 125  // 100 kHz SCL from 50 MHz
) (
    input  logic                   COUNT,
    input  logic                   reset_n,
    input  logic                   start,
    input  logic                   rw,
    input  i2c_reg_pkg::dev_addr_t dev_addr,
    input  i2c_reg_pkg::byte_t     reg_addr,
    input  i2c_reg_pkg::byte_t     wr_data,
    output i2c_reg_pkg::byte_t     rd_data,
    output logic                   busy,
    output logic                   done,
    output logic                   ack_error,
    output logic                   scl_low,
    output logic                   sda_low,
    input  logic                   sda_in
);
    import i2c_reg_pkg::*;

    // Bit command strobe between sequencer and bus timing
    logic     cmd_valid;
    bit_cmd_e bit_cmd;
    logic     tx_bit;
    logic     bit_done;
    logic     rx_bit;

    i2c_byte_controller u_byte_ctrl (
        .COUNT     (COUNT),
        .reset_n   (reset_n),
        .start     (start),
        .rw        (rw),
        .dev_addr  (dev_addr),
        .reg_addr  (reg_addr),
        .wr_data   (wr_data),
        .bit_done  (bit_done),
        .rx_bit    (rx_bit),
        .cmd_valid (cmd_valid),
        .cmd       (bit_cmd),
        .tx_bit    (tx_bit),
        .rd_data   (rd_data),
        .busy      (busy),
        .done      (done),
        .ack_error (ack_error)
    );

    i2c_bit_engine #(
        .CLK_DIV (CLK_DIV)
    ) u_bit_engine (
        .COUNT     (COUNT),
        .reset_n   (reset_n),
        .cmd_valid (cmd_valid),
        .cmd       (bit_cmd),
        .tx_bit    (tx_bit),
        .sda_in    (sda_in),   // Wired-AND bus level
        .bit_done  (bit_done),
        .rx_bit    (rx_bit),
        .scl_low   (scl_low),
        .sda_low   (sda_low)
    );

endmodule

// File: i2c_reg_pkg.sv
package i2c_reg_pkg;

    // Register address, data byte and shift register width
    typedef logic [7:0] byte_t;

    // 7-bit I2C device address, R/W bit appended on the bus
    typedef logic [6:0] dev_addr_t;

    // Bus operations issued by the byte controller to the bit engine
    typedef enum logic [1:0] {
        BIT_START = 2'd0,  // Also used for repeated START
        BIT_STOP  = 2'd1,
        BIT_WRITE = 2'd2,
        BIT_READ  = 2'd3
    } bit_cmd_e;

    // Transaction sequencer states
    typedef enum logic [2:0] {
        IDLE       = 3'd0,
        SEND_START = 3'd1,
        SEND_BYTE  = 3'd2,  // Address, register or data byte, MSB first
        GET_ACK    = 3'd3,
        RECV_BYTE  = 3'd4,
        SEND_NACK  = 3'd5,  // Master NACK after the single read byte
        SEND_STOP  = 3'd6
    } seq_state_e;

endpackage

// File: i2c_slave_model.sv
`timescale 1ns/1ps

module i2c_slave_model #(
    parameter i2c_reg_pkg::dev_addr_t ADDR = 7'h3C
) (
    input  logic COUNT,
    input  logic reset_n,
    input  logic scl,
    input  logic sda,
    output logic sda_low,
    output int   violations,
    output int   stops
);
    import i2c_reg_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_ADDR,
        S_REG,
        S_WDATA,
        S_RDATA,
        S_SKIP   // Not addressed, or read byte already sent
    } slave_state_e;

    slave_state_e state;
    byte_t        mem [256];
    byte_t        ptr;
    byte_t        rx_sh;
    byte_t        tx_sh;
    logic [3:0]   bit_cnt;  // SCL rises in the current byte, ACK slot included
    logic         scl_q;
    logic         sda_q;

    logic         start_cond;
    logic         stop_cond;
    logic         scl_rise;
    logic         scl_fall;

    assign start_cond = scl_q && scl && sda_q && !sda;
    assign stop_cond  = scl_q && scl && !sda_q && sda;
    assign scl_rise   = !scl_q && scl;
    assign scl_fall   = scl_q && !scl;

    always @(posedge COUNT) begin
        if (!reset_n) begin
            state      <= S_IDLE;
            ptr        <= 8'd0;
            bit_cnt    <= 4'd0;
            sda_low    <= 1'b0;
            scl_q      <= 1'b1;
            sda_q      <= 1'b1;
            violations <= 0;
            stops      <= 0;
            for (int a = 0; a < 256; a++)
                mem[a[7:0]] <= {a[3:0], a[7:4]} ^ 8'hA5;
        end else begin
            scl_q <= scl;
            sda_q <= sda;
            if (start_cond || stop_cond) begin
                // Legal only in the first SCL high of a byte
                if (state != S_IDLE && bit_cnt > 4'd1)
                    violations <= violations + 1;
                if (stop_cond)
                    stops <= stops + 1;
                state   <= start_cond ? S_ADDR : S_IDLE;
                bit_cnt <= 4'd0;
                sda_low <= 1'b0;
            end else if (state != S_IDLE) begin
                if (scl_rise) begin
                    bit_cnt <= bit_cnt + 4'd1;
                    if (bit_cnt < 4'd8)
                        rx_sh <= {rx_sh[6:0], sda};
                end
                if (scl_fall && bit_cnt == 4'd9) begin
                    bit_cnt <= 4'd0;
                    sda_low <= 1'b0;
                    if (state == S_RDATA) begin
                        tx_sh   <= mem[ptr];      // Address just acknowledged
                        sda_low <= !mem[ptr][7];
                    end
                end else if (scl_fall && bit_cnt == 4'd8) begin
                    case (state)
                        S_ADDR: begin
                            if (rx_sh[7:1] == ADDR) begin
                                sda_low <= 1'b1;
                                state   <= rx_sh[0] ? S_RDATA : S_REG;
                            end else begin
                                state <= S_SKIP;
                            end
                        end
                        S_REG: begin
                            ptr     <= rx_sh;
                            sda_low <= 1'b1;
                            state   <= S_WDATA;
                        end
                        S_WDATA: begin
                            mem[ptr] <= rx_sh;
                            ptr      <= ptr + 8'd1;
                            sda_low  <= 1'b1;
                        end
                        S_RDATA: begin
                            sda_low <= 1'b0;  // Master answers in the ACK slot
                            state   <= S_SKIP;
                        end
                        default: ;
                    endcase
                end else if (scl_fall && state == S_RDATA && bit_cnt != 4'd0) begin
                    sda_low <= !tx_sh[6];
                    tx_sh   <= {tx_sh[6:0], 1'b0};
                end
            end
        end
    end

endmodule

// File: tb_i2c_reg_master.sv
`timescale 1ns/1ps

module tb_i2c_reg_master;
    import i2c_reg_pkg::*;

    localparam dev_addr_t SLAVE_ADDR   = 7'h3C;
    localparam int        DONE_TIMEOUT = 4000;  // COUNT cycles, a read takes about 700

    logic        COUNT;
    logic        reset_n;
    logic        start;
    logic        rw;
    dev_addr_t   dev_addr;
    byte_t       reg_addr;
    byte_t       wr_data;
    byte_t       rd_data;
    logic        busy;
    logic        done;
    logic        ack_error;
    logic        scl_low;
    logic        sda_low;
    logic        slave_sda_low;
    logic        scl;
    logic        sda;
    int          violations;
    int          stops;

    byte_t       model_mem [256];
    byte_t       touched [$];   // Registers hit by a wrong device address
    logic [31:0] lfsr;
    int          check_errors;
    int          timeouts;
    int          done_cnt;

    assign scl = !scl_low;
    assign sda = !(sda_low || slave_sda_low);  // Wired-AND

    i2c_reg_master #(
        .CLK_DIV (4)
    ) dut (
        .COUNT     (COUNT),
        .reset_n   (reset_n),
        .start     (start),
        .rw        (rw),
        .dev_addr  (dev_addr),
        .reg_addr  (reg_addr),
        .wr_data   (wr_data),
        .rd_data   (rd_data),
        .busy      (busy),
        .done      (done),
        .ack_error (ack_error),
        .scl_low   (scl_low),
        .sda_low   (sda_low),
        .sda_in    (sda)
    );

    i2c_slave_model #(
        .ADDR (SLAVE_ADDR)
    ) u_slave (
        .COUNT      (COUNT),
        .reset_n    (reset_n),
        .scl        (scl),
        .sda        (sda),
        .sda_low    (slave_sda_low),
        .violations (violations),
        .stops      (stops)
    );

    initial begin
        COUNT = 1'b0;
        forever #20 COUNT = ~COUNT;
    end

    always @(posedge COUNT) begin
        if (!reset_n)
            done_cnt <= 0;
        else if (done)
            done_cnt <= done_cnt + 1;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32 22 2 1
    endfunction

    task automatic random_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    // Power-up contents of the slave register file
    function automatic byte_t fill_value(input byte_t a);
        return {a[3:0], a[7:4]} ^ 8'hA5;
    endfunction

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            check_errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            check_errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            check_errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // One request, optionally with a second start while busy
    task automatic run_xfer(input logic op_rw, input dev_addr_t op_dev, input byte_t op_reg,
                            input byte_t op_data, input bit collide,
                            output byte_t got_data, output logic got_err);
        int waited;
        start    = 1'b1;
        rw       = op_rw;
        dev_addr = op_dev;
        reg_addr = op_reg;
        wr_data  = op_data;
        @(posedge COUNT);
        #2;
        start = 1'b0;
        if (collide) begin
            check_flag("busy", busy, 1'b1);
            start    = 1'b1;
            rw       = 1'b0;
            reg_addr = op_reg ^ 8'h01;
            wr_data  = ~op_data;
            @(posedge COUNT);
            #2;
            start = 1'b0;
        end
        waited = 0;
        while (!done && waited < DONE_TIMEOUT) begin
            @(posedge COUNT);
            #2;
            waited++;
        end
        if (!done) begin
            timeouts++;
            $display("Timeout: no done within %0d cycles after the start strobe", DONE_TIMEOUT);
        end
        got_data = rd_data;
        got_err  = ack_error;
        @(posedge COUNT);
        #2;
    endtask

    task automatic write_reg(input byte_t r, input byte_t d, input bit collide);
        byte_t unused;
        logic  err;
        run_xfer(1'b0, SLAVE_ADDR, r, d, collide, unused, err);
        check_flag("ack_error", err, 1'b0);
        model_mem[r] = d;
    endtask

    task automatic read_and_compare(input byte_t r);
        byte_t got;
        logic  err;
        run_xfer(1'b1, SLAVE_ADDR, r, 8'h00, 1'b0, got, err);
        check_flag("ack_error", err, 1'b0);
        check_byte("rd_data", got, model_mem[r]);
    endtask

    task automatic send_to_absent_device(input logic op_rw, input byte_t r, input byte_t d,
                                         input dev_addr_t flip);
        byte_t unused;
        logic  err;
        run_xfer(op_rw, SLAVE_ADDR ^ (flip | 7'h01), r, d, 1'b0, unused, err);
        check_flag("ack_error", err, 1'b1);
        touched.push_back(r);
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] d;
        logic [31:0] ctl;
        logic [31:0] f;
        int          n0;
        int          waited;
        lfsr         = 32'h24aff11a;
        check_errors = 0;
        timeouts     = 0;
        reset_n      = 1'b0;
        start        = 1'b0;
        rw           = 1'b0;
        dev_addr     = SLAVE_ADDR;
        reg_addr     = 8'h00;
        wr_data      = 8'h00;
        for (int a = 0; a < 256; a++)
            model_mem[a[7:0]] = fill_value(a[7:0]);
        repeat (2) @(posedge COUNT);
        #2;
        reset_n = 1'b1;

        // Idle bus before any request
        check_flag("busy", busy, 1'b0);
        check_flag("scl_low", scl_low, 1'b0);
        check_flag("sda_low", sda_low, 1'b0);

        for (int i = 0; i < 40; i++) begin
            random_bits(8, r);
            random_bits(8, d);
            random_bits(4, ctl);  // Bit 0 direction, bits 3:1 zero for a wrong address
            if (ctl[3:1] == 3'd0) begin
                random_bits(7, f);
                send_to_absent_device(ctl[0], r[7:0], d[7:0], f[6:0]);
            end else if (ctl[0]) begin
                read_and_compare(r[7:0]);
            end else begin
                write_reg(r[7:0], d[7:0], 1'b0);
            end
        end

        random_bits(8, r);
        random_bits(8, d);
        send_to_absent_device(1'b0, r[7:0], d[7:0], 7'h40);
        foreach (touched[k])
            read_and_compare(touched[k]);

        // Second start while busy must be dropped
        random_bits(8, r);
        random_bits(8, d);
        n0 = done_cnt;
        write_reg(r[7:0], d[7:0], 1'b1);
        // A queued second request would finish inside this window
        waited = 0;
        while (!done && waited < DONE_TIMEOUT) begin
            @(posedge COUNT);
            #2;
            waited++;
        end
        @(posedge COUNT);
        #2;
        check_flag("busy", busy, 1'b0);
        check_count("done strobes", done_cnt - n0, 1);
        read_and_compare(r[7:0]);
        read_and_compare(r[7:0] ^ 8'h01);

        check_count("protocol violations", violations, 0);
        check_count("STOP conditions", stops, done_cnt);
        $display("Errors: %0d check, %0d timeout", check_errors, timeouts);
        if (check_errors == 0 && timeouts == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
